// ==== rtl/game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ********************
// screen geometry and fixed point.
// ********************
`define GAME_COORD_W      11
`define GAME_FRAC_BITS    8

// missile pool and body size.
`define GAME_SHOT_AMOUNT  7
`define GAME_OBJ_W        2
`define GAME_OBJ_H        5
`define GAME_X_OFFSET     15   // relative to ship corner.
`define GAME_Y_OFFSET     0
`define GAME_X_SPEED      0    // straight up only.
`define GAME_SPEED_RESET  (-256)
`define GAME_COLOR_RESET  8'h1F

// ********************
// register map, byte offsets.
// ********************
`define GAME_ADDR_CTRL    8'h00
`define GAME_ADDR_COLOR   8'h04
`define GAME_ADDR_SPEED   8'h08
`define GAME_ADDR_STATUS  8'h0C
`define GAME_ADDR_SHOTS   8'h10

`endif

// ==== rtl/game_pkg.sv ====
`include "game_defs.svh"

package game_pkg;

    // signed pixel coordinate, may go off screen.
    typedef logic signed [`GAME_COORD_W-1:0] coordinate;

    // coordinate with fraction bits below the pixel.
    typedef logic signed [`GAME_COORD_W+`GAME_FRAC_BITS-1:0] fixed_point;

    typedef logic [7:0] rgb;

    typedef struct packed {
        coordinate x;
        coordinate y;
    } pixelPos;

    // ********************
    // APB request and response.
    // ********************
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp;

    typedef struct packed {
        logic       fireEnable;
        rgb         color;
        fixed_point ySpeed;   // per frame, negative is up.
    } missileCfg;

endpackage

// ==== rtl/square_object.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module square_object #(
    parameter int OBJECT_W = `GAME_OBJ_W,
    parameter int OBJECT_H = `GAME_OBJ_H
) (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::pixelPos scanPos,
    input  game_pkg::pixelPos corner,
    output logic              drawReq
);

    game_pkg::coordinate rightEdge;     // exclusive.
    game_pkg::coordinate bottomEdge;    // exclusive.
    logic                insideX;
    logic                insideY;

    assign rightEdge  = corner.x + game_pkg::coordinate'(OBJECT_W);
    assign bottomEdge = corner.y + game_pkg::coordinate'(OBJECT_H);

    assign insideX = (scanPos.x >= corner.x) && (scanPos.x < rightEdge);
    assign insideY = (scanPos.y >= corner.y) && (scanPos.y < bottomEdge);

    // one cycle behind the scan pixel.
    always_ff @(posedge clk) begin
        if (rst) begin
            drawReq <= 1'b0;
        end else begin
            drawReq <= insideX && insideY;
        end
    end

endmodule

// ==== rtl/missile_movement.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missile_movement (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 startOfFrame,
    input  logic                 fire,
    input  logic                 hit,
    input  game_pkg::fixed_point ySpeed,
    input  game_pkg::pixelPos    launchPos,
    output game_pkg::pixelPos    corner,
    output logic                 active
);

    localparam int FIX_W = $bits(game_pkg::fixed_point);

    game_pkg::fixed_point xFix;
    game_pkg::fixed_point yFix;
    game_pkg::fixed_point xNext;
    game_pkg::fixed_point yNext;

    // position after one frame of motion.
    assign xNext = xFix + game_pkg::fixed_point'(`GAME_X_SPEED);
    assign yNext = yFix + ySpeed;

    // ********************
    // slot state
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (fire) begin
            active <= 1'b1;                  // launch wins over everything.
        end else if (active && hit) begin
            active <= 1'b0;                  // struck while drawing.
        end else if (active && startOfFrame && yNext < 0) begin
            active <= 1'b0;                  // left the top edge.
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            xFix <= {launchPos.x, {`GAME_FRAC_BITS{1'b0}}};
            yFix <= {launchPos.y, {`GAME_FRAC_BITS{1'b0}}};
        end else if (active && startOfFrame) begin
            xFix <= xNext;
            yFix <= yNext;
        end
    end

    // drop the fraction for drawing.
    assign corner = '{
        x: xFix[FIX_W-1 -: `GAME_COORD_W],
        y: yFix[FIX_W-1 -: `GAME_COORD_W]
    };

    // the pool picker must only pick idle slots.
    fireOnlyWhenIdle: assert property (
        @(posedge clk) disable iff (rst) fire |-> !active
    );

endmodule

// ==== rtl/missile_pool.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missile_pool #(
    parameter int SHOT_AMOUNT = `GAME_SHOT_AMOUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   shootPulse,
    input  logic                   startOfFrame,
    input  logic                   collision,
    input  game_pkg::pixelPos      scanPos,
    input  game_pkg::pixelPos      shipPos,
    input  game_pkg::missileCfg    cfg,
    output logic [SHOT_AMOUNT-1:0] activeMask,
    output logic                   launch,
    output logic                   missileDR,
    output game_pkg::rgb           missileRGB
);

    logic [SHOT_AMOUNT-1:0] fireCmd;
    logic [SHOT_AMOUNT-1:0] drawReq;
    logic                   fireGated;
    game_pkg::pixelPos      launchPos;
    game_pkg::pixelPos      corners [SHOT_AMOUNT];

    assign fireGated = shootPulse && cfg.fireEnable;

    // shared by all slots.
    assign launchPos = '{
        x: shipPos.x + game_pkg::coordinate'(`GAME_X_OFFSET),
        y: shipPos.y + game_pkg::coordinate'(`GAME_Y_OFFSET)
    };

    // ********************
    // lowest idle slot gets the shot
    // ********************
    always_comb begin
        logic found;
        fireCmd = '0;
        found   = 1'b0;
        for (int j = 0; j < SHOT_AMOUNT; j++) begin
            if (!activeMask[j] && !found) begin
                fireCmd[j] = fireGated;
                found      = 1'b1;
            end
        end
    end

    assign launch = |fireCmd;   // dropped when pool is full.

    for (genvar i = 0; i < SHOT_AMOUNT; i++) begin : slot
        missile_movement slotMove (
            .clk          (clk),
            .rst          (rst),
            .startOfFrame (startOfFrame),
            .fire         (fireCmd[i]),
            .hit          (collision && drawReq[i]),  // only the one drawn here.
            .ySpeed       (cfg.ySpeed),
            .launchPos    (launchPos),
            .corner       (corners[i]),
            .active       (activeMask[i])
        );

        square_object slotShape (
            .clk     (clk),
            .rst     (rst),
            .scanPos (scanPos),
            .corner  (corners[i]),
            .drawReq (drawReq[i])
        );
    end

    assign missileDR  = |(drawReq & activeMask);
    assign missileRGB = cfg.color;

    oneFireAtATime: assert property (
        @(posedge clk) disable iff (rst) $onehot0(fireCmd)
    );

    // target was idle, and is active one edge later.
    launchTakesIdleSlot: assert property (
        @(posedge clk) disable iff (rst)
        launch |-> ((fireCmd & activeMask) == '0)
            ##1 ((activeMask & $past(fireCmd)) == $past(fireCmd))
    );

endmodule

// ==== rtl/missile_regs.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missile_regs #(
    parameter int SHOT_AMOUNT = `GAME_SHOT_AMOUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::apbReq        apbIn,
    output game_pkg::apbRsp        apbOut,
    input  logic [SHOT_AMOUNT-1:0] activeMask,
    input  logic                   launch,
    output game_pkg::missileCfg    cfg
);

    localparam int FIX_W = $bits(game_pkg::fixed_point);

    logic                 access;
    logic                 mapped;
    logic                 readOnly;
    logic                 wrEn;
    logic                 fireEnable;
    game_pkg::rgb         color;
    game_pkg::fixed_point ySpeed;
    logic [15:0]          shotCount;
    logic [31:0]          readData;

    assign access = apbIn.psel && apbIn.penable;

    // ********************
    // address decode and read mux
    // ********************
    always_comb begin
        mapped   = 1'b1;
        readOnly = 1'b0;
        readData = '0;
        case (apbIn.paddr)
            `GAME_ADDR_CTRL:   readData = {31'b0, fireEnable};
            `GAME_ADDR_COLOR:  readData = {24'b0, color};
            `GAME_ADDR_SPEED:  readData = 32'(ySpeed);   // sign extended.
            `GAME_ADDR_STATUS: begin
                readData = 32'(activeMask);
                readOnly = 1'b1;
            end
            `GAME_ADDR_SHOTS: begin
                readData = {16'b0, shotCount};
                readOnly = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign wrEn = access && apbIn.pwrite && mapped && !readOnly;

    always_ff @(posedge clk) begin
        if (rst) begin
            fireEnable <= 1'b1;
            color      <= `GAME_COLOR_RESET;
            ySpeed     <= game_pkg::fixed_point'(`GAME_SPEED_RESET);
        end else if (wrEn) begin
            case (apbIn.paddr)
                `GAME_ADDR_CTRL:  fireEnable <= apbIn.pwdata[0];
                `GAME_ADDR_COLOR: color      <= apbIn.pwdata[7:0];
                `GAME_ADDR_SPEED: ySpeed     <= apbIn.pwdata[FIX_W-1:0];
                default: ;
            endcase
        end
    end

    // launch counter, wraps.
    always_ff @(posedge clk) begin
        if (rst) begin
            shotCount <= '0;
        end else if (launch) begin
            shotCount <= shotCount + 16'd1;
        end
    end

    assign apbOut = '{
        prdata:  readData,
        pready:  1'b1,                                    // no wait states.
        pslverr: access && (!mapped || (apbIn.pwrite && readOnly))
    };

    assign cfg = '{fireEnable: fireEnable, color: color, ySpeed: ySpeed};

    // access phase must follow a setup phase.
    apbSetupFirst: assert property (
        @(posedge clk) disable iff (rst) apbIn.penable |-> $past(apbIn.psel)
    );

endmodule

// ==== rtl/missiles_top.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missiles_top (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::apbReq   apbIn,
    output game_pkg::apbRsp   apbOut,
    input  logic              shootPulse,
    input  logic              startOfFrame,
    input  logic              collision,
    input  game_pkg::pixelPos scanPos,
    input  game_pkg::pixelPos shipPos,
    output logic              missileDR,
    output game_pkg::rgb      missileRGB
);

    game_pkg::missileCfg          cfg;
    logic [`GAME_SHOT_AMOUNT-1:0] activeMask;   // feeds STATUS.
    logic                         launch;       // feeds SHOTS.

    missile_regs #(.SHOT_AMOUNT(`GAME_SHOT_AMOUNT)) regs0 (
        .clk        (clk),
        .rst        (rst),
        .apbIn      (apbIn),
        .apbOut     (apbOut),
        .activeMask (activeMask),
        .launch     (launch),
        .cfg        (cfg)
    );

    missile_pool #(.SHOT_AMOUNT(`GAME_SHOT_AMOUNT)) pool0 (
        .clk          (clk),
        .rst          (rst),
        .shootPulse   (shootPulse),
        .startOfFrame (startOfFrame),
        .collision    (collision),
        .scanPos      (scanPos),
        .shipPos      (shipPos),
        .cfg          (cfg),
        .activeMask   (activeMask),
        .launch       (launch),
        .missileDR    (missileDR),
        .missileRGB   (missileRGB)
    );

endmodule

// ==== verification/missiles_checks.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missiles_checks #(
    parameter int SHOT_AMOUNT = `GAME_SHOT_AMOUNT
) (
    input logic              clk,
    input logic              rst,
    input game_pkg::apbReq   apbIn,
    input game_pkg::apbRsp   apbOut,
    input logic              shootPulse,
    input logic              startOfFrame,
    input logic              collision,
    input game_pkg::pixelPos scanPos,
    input game_pkg::pixelPos shipPos,
    input logic              missileDR,
    input game_pkg::rgb      missileRGB,
    input string             testName
);

    localparam int FRAC_ONE = 1 << `GAME_FRAC_BITS;
    localparam int SPEED_W  = `GAME_COORD_W + `GAME_FRAC_BITS;

    int                     errCount = 0;   // read by the testbench.
    logic                   refEnable;
    game_pkg::rgb           refColor;
    logic signed [31:0]     refSpeed;       // 1/256 pixel per frame.
    logic [15:0]            refShots;
    logic [SHOT_AMOUNT-1:0] refActive;
    logic [SHOT_AMOUNT-1:0] refHit;         // body hit, one cycle late.
    int                     refX [SHOT_AMOUNT];
    int                     refY [SHOT_AMOUNT];
    logic                   access;
    logic                   refDR;
    logic [31:0]            expRead;
    logic                   expErr;

    function automatic logic inRect(input int cornerX, input int cornerY,
                                    input game_pkg::pixelPos p);
        int px;
        int py;
        px = int'(p.x);
        py = int'(p.y);
        return (px >= cornerX) && (px < cornerX + `GAME_OBJ_W)
            && (py >= cornerY) && (py < cornerY + `GAME_OBJ_H);
    endfunction

    task automatic reportValue(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        errCount++;
        $display("FAIL %0s (%0s): expected 0x%0h, actual 0x%0h",
                 testName, what, expected, actual);
    endtask

    // ********************
    // reference model
    // ********************
    always_ff @(posedge clk) begin
        logic launched;
        int   nextY;
        if (rst) begin
            refEnable <= 1'b1;
            refColor  <= `GAME_COLOR_RESET;
            refSpeed  <= `GAME_SPEED_RESET;
            refShots  <= '0;
            refActive <= '0;
            refHit    <= '0;
        end else begin
            if (access && apbIn.pwrite) begin
                case (apbIn.paddr)
                    `GAME_ADDR_CTRL:  refEnable <= apbIn.pwdata[0];
                    `GAME_ADDR_COLOR: refColor  <= apbIn.pwdata[7:0];
                    `GAME_ADDR_SPEED: refSpeed  <= 32'($signed(apbIn.pwdata[SPEED_W-1:0]));
                    default: ;                               // read only or unmapped.
                endcase
            end
            launched = 1'b0;
            for (int i = 0; i < SHOT_AMOUNT; i++) begin
                refHit[i] <= inRect(refX[i] >>> `GAME_FRAC_BITS,
                                    refY[i] >>> `GAME_FRAC_BITS, scanPos);
                nextY = refY[i] + refSpeed;
                if (!refActive[i] && shootPulse && refEnable && !launched) begin
                    launched     = 1'b1;                     // lowest idle slot.
                    refActive[i] <= 1'b1;
                    refX[i]      <= (int'(shipPos.x) + `GAME_X_OFFSET) * FRAC_ONE;
                    refY[i]      <= (int'(shipPos.y) + `GAME_Y_OFFSET) * FRAC_ONE;
                end else if (refActive[i] && collision && refHit[i]) begin
                    refActive[i] <= 1'b0;
                end else if (refActive[i] && startOfFrame) begin
                    refX[i]      <= refX[i] + `GAME_X_SPEED;
                    refY[i]      <= nextY;
                    refActive[i] <= (nextY >= 0);            // off the top retires.
                end
            end
            if (launched) begin
                refShots <= refShots + 16'd1;
            end
        end
    end

    assign access = apbIn.psel && apbIn.penable;
    assign refDR  = |(refHit & refActive);

    always_comb begin
        expRead = '0;
        expErr  = 1'b0;
        case (apbIn.paddr)
            `GAME_ADDR_CTRL:   expRead = {31'b0, refEnable};
            `GAME_ADDR_COLOR:  expRead = {24'b0, refColor};
            `GAME_ADDR_SPEED:  expRead = refSpeed;
            `GAME_ADDR_STATUS: begin
                expRead = 32'(refActive);
                expErr  = apbIn.pwrite;
            end
            `GAME_ADDR_SHOTS: begin
                expRead = {16'b0, refShots};
                expErr  = apbIn.pwrite;
            end
            default: expErr = 1'b1;
        endcase
        expErr = expErr && access;
    end

    // ********************
    // comparisons
    // ********************
    drawMatches: assert property (@(posedge clk) disable iff (rst) missileDR == refDR)
        else reportValue("missileDR", 32'($sampled(refDR)), 32'($sampled(missileDR)));

    colorMatches: assert property (@(posedge clk) disable iff (rst) missileRGB == refColor)
        else reportValue("missileRGB", 32'($sampled(refColor)), 32'($sampled(missileRGB)));

    readMatches: assert property (@(posedge clk) disable iff (rst)
        (access && !apbIn.pwrite) |-> apbOut.prdata == expRead)
        else reportValue("prdata", $sampled(expRead), $sampled(apbOut.prdata));

    errorMatches: assert property (@(posedge clk) disable iff (rst)
        apbOut.pslverr == expErr)
        else reportValue("pslverr", 32'($sampled(expErr)), 32'($sampled(apbOut.pslverr)));

    // zero wait states on every transfer.
    readyHigh: assert property (@(posedge clk) disable iff (rst) apbOut.pready == 1'b1)
        else reportValue("pready", 32'd1, 32'($sampled(apbOut.pready)));

endmodule

// ==== verification/missiles_tb.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module missiles_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 60 + 120 + 160 + 60 + 60;   // per test, reset included.
    localparam logic [7:0] UNMAPPED = 8'h14;

    logic              clk;
    logic              rst;
    game_pkg::apbReq   apbIn;
    game_pkg::apbRsp   apbOut;
    logic              shootPulse;
    logic              startOfFrame;
    logic              collision;
    game_pkg::pixelPos scanPos;
    game_pkg::pixelPos shipPos;
    logic              missileDR;
    game_pkg::rgb      missileRGB;

    string             testName = "init";
    int                seed = 74;
    int                errCount = 0;
    int                errBase = 0;
    int                testsRun = 0;
    int                testsFailed = 0;

    missiles_top dut0 (
        .clk(clk), .rst(rst), .apbIn(apbIn), .apbOut(apbOut),
        .shootPulse(shootPulse), .startOfFrame(startOfFrame), .collision(collision),
        .scanPos(scanPos), .shipPos(shipPos), .missileDR(missileDR), .missileRGB(missileRGB)
    );

    missiles_checks chk0 (
        .clk(clk), .rst(rst), .apbIn(apbIn), .apbOut(apbOut),
        .shootPulse(shootPulse), .startOfFrame(startOfFrame), .collision(collision),
        .scanPos(scanPos), .shipPos(shipPos), .missileDR(missileDR),
        .missileRGB(missileRGB), .testName(testName)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("timeout: tests still running after %0d ns", TEST_CYCLES * CLK_PERIOD * 2);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ********************
    // stimulus tasks
    // ********************
    task automatic nextCycle();
        @(posedge clk);
        #1;                                                      // drive after the edge.
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        valueCheck: assert (actual == expected) else begin
            errCount++;
            $display("FAIL %0s (%0s): expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        nextCycle();
        apbIn.penable = 1'b1;
        #1;
        rdata = apbOut.prdata;                                   // access phase.
        err   = apbOut.pslverr;
        nextCycle();
        apbIn = '0;
    endtask

    task automatic regWrite(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, addr, data, rdata, err);
    endtask

    task automatic expectRead(input string what, input logic [7:0] addr,
                              input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b0, addr, '0, rdata, err);
        checkValue(what, expected, rdata);
    endtask

    task automatic expectError(input string what, input logic write, input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(write, addr, 32'hFFFF_FFFF, rdata, err);
        checkValue(what, 32'd1, 32'(err));
    endtask

    task automatic firePulse(input int x, input int y);
        shipPos    = '{x: game_pkg::coordinate'(x), y: game_pkg::coordinate'(y)};
        shootPulse = 1'b1;
        nextCycle();
        shootPulse = 1'b0;
    endtask

    task automatic frames(input int count);
        repeat (count) begin
            startOfFrame = 1'b1;
            nextCycle();
            startOfFrame = 1'b0;
            nextCycle();
        end
    endtask

    // result shows one cycle after the pixel is sampled.
    task automatic probeCheck(input string what, input int x, input int y, input logic expDr,
                              input game_pkg::rgb expColor, input logic hitIt);
        scanPos = '{x: game_pkg::coordinate'(x), y: game_pkg::coordinate'(y)};
        nextCycle();
        checkValue(what, 32'(expDr), 32'(missileDR));
        if (expDr) begin
            checkValue({what, " colour"}, 32'(expColor), 32'(missileRGB));
        end
        collision = hitIt;                                       // aligned with missileDR.
        nextCycle();
        collision = 1'b0;
        scanPos   = '{x: 11'sd1000, y: 11'sd1000};               // parked off every body.
    endtask

    task automatic motionCase(input logic [31:0] speedWord, input int step);
        int           px;
        int           py;
        int           n;
        game_pkg::rgb color;
        px    = 16 + ($random(seed) & 255);
        py    = 40 + ($random(seed) & 63);
        n     = 4 + ($random(seed) & 7);
        color = game_pkg::rgb'($random(seed));
        regWrite(`GAME_ADDR_SPEED, speedWord);
        regWrite(`GAME_ADDR_COLOR, 32'(color));
        firePulse(px, py);
        frames(n);
        probeCheck("body pixel", px + `GAME_X_OFFSET, py - step * n, 1'b1, color, 1'b0);
        probeCheck("right of body", px + `GAME_X_OFFSET + `GAME_OBJ_W, py - step * n,
                   1'b0, color, 1'b0);
        probeCheck("below body", px + `GAME_X_OFFSET, py - step * n + `GAME_OBJ_H,
                   1'b0, color, 1'b0);
    endtask

    task automatic startTest(input string name);
        testName = name;
        errBase  = errCount + chk0.errCount;
        applyReset();
    endtask

    task automatic finishTest();
        int errs;
        errs = errCount + chk0.errCount - errBase;
        testsRun++;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("test %0s: %0s, %0d errors", testName, (errs == 0) ? "ok" : "failed", errs);
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        int x;
        int y;
        rst          = 1'b1;
        apbIn        = '0;
        shootPulse   = 1'b0;
        startOfFrame = 1'b0;
        collision    = 1'b0;
        scanPos      = '{x: 11'sd1000, y: 11'sd1000};
        shipPos      = '0;

        startTest("registers");
        checkValue("missileDR after reset", 32'd0, 32'(missileDR));
        expectRead("CTRL reset", `GAME_ADDR_CTRL, 32'd1);
        expectRead("COLOR reset", `GAME_ADDR_COLOR, 32'(`GAME_COLOR_RESET));
        expectRead("SPEED reset", `GAME_ADDR_SPEED, 32'hFFFF_FF00);
        regWrite(`GAME_ADDR_COLOR, 32'h0000_005A);
        regWrite(`GAME_ADDR_SPEED, 32'hFFFF_FE80);               // -1.5 pixel per frame.
        expectRead("COLOR write", `GAME_ADDR_COLOR, 32'h5A);
        expectRead("SPEED write", `GAME_ADDR_SPEED, 32'hFFFF_FE80);
        expectError("write 0x14", 1'b1, UNMAPPED);
        expectError("read 0x14", 1'b0, UNMAPPED);
        expectError("write STATUS", 1'b1, `GAME_ADDR_STATUS);
        expectRead("COLOR kept", `GAME_ADDR_COLOR, 32'h5A);
        expectRead("SPEED kept", `GAME_ADDR_SPEED, 32'hFFFF_FE80);
        expectRead("STATUS kept", `GAME_ADDR_STATUS, 32'd0);
        finishTest();

        startTest("allocation");
        for (int i = 0; i < `GAME_SHOT_AMOUNT; i++) begin
            firePulse(16 + ($random(seed) & 255), 40 + ($random(seed) & 63));
            expectRead("STATUS fill", `GAME_ADDR_STATUS, (32'd1 << (i + 1)) - 32'd1);
        end
        expectRead("SHOTS full", `GAME_ADDR_SHOTS, 32'(`GAME_SHOT_AMOUNT));
        firePulse(100, 100);
        expectRead("STATUS pool full", `GAME_ADDR_STATUS, (32'd1 << `GAME_SHOT_AMOUNT) - 32'd1);
        expectRead("SHOTS pool full", `GAME_ADDR_SHOTS, 32'(`GAME_SHOT_AMOUNT));
        applyReset();
        regWrite(`GAME_ADDR_CTRL, 32'd0);
        firePulse(100, 100);
        expectRead("STATUS disabled", `GAME_ADDR_STATUS, 32'd0);
        expectRead("SHOTS disabled", `GAME_ADDR_SHOTS, 32'd0);
        finishTest();

        startTest("motion");
        motionCase(32'hFFFF_FF00, 1);
        applyReset();
        motionCase(32'hFFFF_FE00, 2);
        finishTest();

        startTest("collision");
        x = 16 + ($random(seed) & 255);
        y = 40 + ($random(seed) & 63);
        firePulse(x, y);
        firePulse(x + 40, y + 20);
        expectRead("STATUS two shots", `GAME_ADDR_STATUS, 32'h3);
        probeCheck("struck pixel", x + `GAME_X_OFFSET, y, 1'b1, `GAME_COLOR_RESET, 1'b1);
        expectRead("STATUS after hit", `GAME_ADDR_STATUS, 32'h2);
        probeCheck("other shot", x + 40 + `GAME_X_OFFSET, y + 20, 1'b1, `GAME_COLOR_RESET, 1'b0);
        finishTest();

        startTest("top edge");
        x = 16 + ($random(seed) & 255);
        firePulse(x, 3);
        frames(3);
        expectRead("STATUS at y 0", `GAME_ADDR_STATUS, 32'd1);
        frames(1);
        expectRead("STATUS left top", `GAME_ADDR_STATUS, 32'd0);
        probeCheck("retired pixel", x + `GAME_X_OFFSET, 0, 1'b0, `GAME_COLOR_RESET, 1'b0);
        finishTest();

        $display("tests run %0d, failed %0d, errors %0d",
                 testsRun, testsFailed, errCount + chk0.errCount);
        if (testsFailed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/game_pkg.sv
rtl/square_object.sv
rtl/missile_movement.sv
rtl/missile_pool.sv
rtl/missile_regs.sv
rtl/missiles_top.sv
verification/missiles_checks.sv
verification/missiles_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the missile testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_EXE=missiles_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module missiles_tb \
    -f all.f \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./"$BUILD_DIR"/"$SIM_EXE" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
